//--- common/mix_pkg.sv
// mix_pkg: widths, limits and bus structs shared by the two-channel audio mixer
package mix_pkg;

    // audio sample width, signed
    localparam int SAMPLE_W = 16;
    // pole coefficient, fraction bits only (a = coef/256)
    localparam int COEF_W = 8;
    // gain is unsigned Q4.4
    localparam int GAIN_W = 8;
    localparam int GAIN_FRAC = 4;
    localparam int NUM_CH = 2;

    // output flow control
    localparam int CREDITS_MAX = 4;
    localparam int CREDIT_W = $clog2(CREDITS_MAX + 1);
    // drop counter, saturating
    localparam int DROP_W = 8;

    // two guard bits for the channel sum
    localparam int SUM_W = SAMPLE_W + 2;

    // clamp limits of a signed sample
    localparam logic signed [SAMPLE_W-1:0] SAMPLE_MAX = (2 ** (SAMPLE_W - 1)) - 1;
    localparam logic signed [SAMPLE_W-1:0] SAMPLE_MIN = -(2 ** (SAMPLE_W - 1));

    // one sample per channel
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] ch0;
        logic signed [SAMPLE_W-1:0] ch1;
    } mix_frame_t;

    // per channel settings: two poles and a gain
    typedef struct packed {
        logic [COEF_W-1:0] a1;
        logic [COEF_W-1:0] a2;
        logic [GAIN_W-1:0] gain;
    } chan_cfg_t;

    typedef struct packed {
        chan_cfg_t ch0;
        chan_cfg_t ch1;
    } mix_cfg_t;

    // one output beat, clip is set when any stage saturated
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] data;
        logic                       clip;
    } mix_out_t;

endpackage

//--- design/pole/pole_filter.sv
// pole_filter: single-pole IIR low pass, y = a*y_prev + (1-a)*x, one shared multiplier
`timescale 1ns/10ps

module pole_filter #(
    parameter int WS = 16,
    // fraction bits of a
    parameter int WA = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sample,
    input  logic signed [WS-1:0] sin,
    input  logic        [WA-1:0] a,
    output logic signed [WS-1:0] sout
);

    // 1.0 in the coefficient's fixed point
    localparam logic signed [WS-1:0] ONE = WS'(1) << WA;

    logic signed [WS-1:0]   aext;
    logic signed [WS-1:0]   factor;
    logic signed [WS-1:0]   fmux;
    logic signed [2*WS-1:0] prod;
    // a*y_prev, formed between strobes
    logic signed [WS-1:0]   last_prod;

    assign aext = {{(WS - WA){1'b0}}, a};

    // strobe: (1-a)*x, otherwise a*y_prev
    always_comb begin
        factor = sample ? (ONE - aext) : aext;
        fmux   = sample ? sin : sout;
        prod   = factor * fmux;
    end

    // dropping the low WA bits of a signed product floors toward minus infinity
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sout      <= '0;
            last_prod <= '0;
        end else if (sample) begin
            // a of zero passes the input straight through
            sout <= (a == '0) ? sin : last_prod + prod[WS+WA-1:WA];
        end else begin
            last_prod <= prod[WS+WA-1:WA];
        end
    end

    // a*y_prev needs a quiet cycle after each strobe
    a_strobe_gap : assert property (
        @(posedge clk) disable iff (rst) sample |=> !sample
    ) else $error("pole_filter: strobes in consecutive cycles");

endmodule

//--- design/pole/pole_cascade.sv
// pole_cascade: two pole sections in series forming a two-pole low pass for one channel
`timescale 1ns/10ps

module pole_cascade
    import mix_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       sample,
    input  logic signed [SAMPLE_W-1:0] x,
    input  logic        [COEF_W-1:0]   a1,
    input  logic        [COEF_W-1:0]   a2,
    output logic signed [SAMPLE_W-1:0] y,
    // strobe aligned with y
    output logic                       sample_d
);

    logic signed [SAMPLE_W-1:0] y1;
    // strobe for the second section, one cycle late
    logic                       sample_1;

    // first section updates the cycle after the strobe
    pole_filter #(
        .WS (SAMPLE_W),
        .WA (COEF_W)
    ) i_pole_1 (
        .clk    (clk),
        .rst    (rst),
        .sample (sample),
        .sin    (x),
        .a      (a1),
        .sout   (y1)
    );

    // second section sees y1 once it has settled
    pole_filter #(
        .WS (SAMPLE_W),
        .WA (COEF_W)
    ) i_pole_2 (
        .clk    (clk),
        .rst    (rst),
        .sample (sample_1),
        .sin    (y1),
        .a      (a2),
        .sout   (y)
    );

    // strobe pipe: sample_1 feeds pole 2, sample_d marks a new y
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sample_1 <= 1'b0;
            sample_d <= 1'b0;
        end else begin
            sample_1 <= sample;
            sample_d <= sample_1;
        end
    end

endmodule

//--- design/chan_gain.sv
// chan_gain: registered Q4.4 gain on one channel with clamp to sample range
`timescale 1ns/10ps

module chan_gain
    import mix_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       sample_d,
    input  logic signed [SAMPLE_W-1:0] x,
    input  logic        [GAIN_W-1:0]   gain,
    output logic signed [SAMPLE_W-1:0] g,
    output logic                       clip,
    output logic                       g_valid
);

    // signed sample times gain with a zero sign bit
    localparam int PROD_W = SAMPLE_W + GAIN_W + 1;

    logic signed [PROD_W-1:0] prod;
    logic signed [PROD_W-1:0] prod_sh;

    always_comb begin
        prod    = x * $signed({1'b0, gain});
        // floor of prod/16
        prod_sh = prod >>> GAIN_FRAC;
    end

    // result only moves on the aligned strobe
    always_ff @(posedge clk) begin
        if (sample_d) begin
            if (prod_sh > SAMPLE_MAX) begin
                g    <= SAMPLE_MAX;
                clip <= 1'b1;
            end else if (prod_sh < SAMPLE_MIN) begin
                g    <= SAMPLE_MIN;
                clip <= 1'b1;
            end else begin
                g    <= prod_sh[SAMPLE_W-1:0];
                clip <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) g_valid <= 1'b0;
        else     g_valid <= sample_d;
    end

endmodule

//--- design/mix_sum.sv
// mix_sum: sums the gained channels at wider width, clamps, and flags clipping
`timescale 1ns/10ps

module mix_sum
    import mix_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       g_valid,
    input  logic signed [SAMPLE_W-1:0] g0,
    input  logic signed [SAMPLE_W-1:0] g1,
    input  logic                       clip0,
    input  logic                       clip1,
    output logic                       res_valid,
    output mix_out_t                   res
);

    logic signed [SUM_W-1:0]    sum_w;
    logic signed [SAMPLE_W-1:0] sum_sat;
    logic                       sum_clip;

    // sign extend both channels, two spare bits cannot overflow
    always_comb begin
        sum_w = {{(SUM_W - SAMPLE_W){g0[SAMPLE_W-1]}}, g0}
              + {{(SUM_W - SAMPLE_W){g1[SAMPLE_W-1]}}, g1};
    end

    // clamp back to sample range
    always_comb begin
        if (sum_w > SAMPLE_MAX) begin
            sum_sat  = SAMPLE_MAX;
            sum_clip = 1'b1;
        end else if (sum_w < SAMPLE_MIN) begin
            sum_sat  = SAMPLE_MIN;
            sum_clip = 1'b1;
        end else begin
            sum_sat  = sum_w[SAMPLE_W-1:0];
            sum_clip = 1'b0;
        end
    end

    // payload held between results
    always_ff @(posedge clk) begin
        if (g_valid) begin
            res.data <= sum_sat;
            // clipping anywhere upstream is reported too
            res.clip <= sum_clip | clip0 | clip1;
        end
    end

    // one-cycle valid, one cycle behind the gains
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= g_valid;
        end
    end

endmodule

//--- design/credit_out.sv
// credit_out: credit-controlled output register with a saturating drop counter
`timescale 1ns/10ps

module credit_out
    import mix_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              res_valid,
    input  mix_out_t          res,
    input  logic              credit_ret,
    output logic              out_valid,
    output mix_out_t          out_data,
    output logic [DROP_W-1:0] drop_count
);

    logic [CREDIT_W-1:0] credits;
    logic                send;

    // a result goes out only while a credit is held
    assign send = res_valid && (credits != '0);

    // spend on send, refill on return, both together cancel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits <= CREDIT_W'(CREDITS_MAX);
        end else begin
            case ({send, credit_ret})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= send;
        end
    end

    // beat data, only loaded when it is sent
    always_ff @(posedge clk) begin
        if (send) out_data <= res;
    end

    // result without a credit is lost, count it and stick at all ones
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            drop_count <= '0;
        end else if (res_valid && !send && (drop_count != '1)) begin
            drop_count <= drop_count + 1'b1;
        end
    end

    // sink must not hand back credits it never received
    a_credit_max : assert property (
        @(posedge clk) disable iff (rst) credits <= CREDIT_W'(CREDITS_MAX)
    ) else $error("credit_out: more credits returned than granted");

endmodule

//--- design/audio_mix_top.sv
// audio_mix_top: two filtered, gained channels mixed onto a credit-controlled output
`timescale 1ns/10ps

module audio_mix_top
    import mix_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              sample,
    input  mix_frame_t        in_frame,
    input  mix_cfg_t          cfg,
    input  logic              credit_ret,
    output logic              out_valid,
    output mix_out_t          out_data,
    output logic [DROP_W-1:0] drop_count
);

    // cascade outputs, valid with sample_d
    mix_frame_t                 y_frame;
    logic                       sample_d;
    logic signed [SAMPLE_W-1:0] g0;
    logic signed [SAMPLE_W-1:0] g1;
    logic                       clip0;
    logic                       clip1;
    logic                       g_valid;
    logic                       res_valid;
    mix_out_t                   res;

    // both channels share one strobe, so ch0 supplies the delayed copy
    pole_cascade i_cascade_0 (
        .clk (clk), .rst (rst), .sample (sample), .x (in_frame.ch0),
        .a1 (cfg.ch0.a1), .a2 (cfg.ch0.a2), .y (y_frame.ch0), .sample_d (sample_d)
    );
    pole_cascade i_cascade_1 (
        .clk (clk), .rst (rst), .sample (sample), .x (in_frame.ch1),
        .a1 (cfg.ch1.a1), .a2 (cfg.ch1.a2), .y (y_frame.ch1), .sample_d ()
    );

    chan_gain i_gain_0 (
        .clk (clk), .rst (rst), .sample_d (sample_d), .x (y_frame.ch0),
        .gain (cfg.ch0.gain), .g (g0), .clip (clip0), .g_valid (g_valid)
    );
    chan_gain i_gain_1 (
        .clk (clk), .rst (rst), .sample_d (sample_d), .x (y_frame.ch1),
        .gain (cfg.ch1.gain), .g (g1), .clip (clip1), .g_valid ()
    );

    mix_sum i_mix_sum (
        .clk (clk), .rst (rst), .g_valid (g_valid), .g0 (g0), .g1 (g1),
        .clip0 (clip0), .clip1 (clip1), .res_valid (res_valid), .res (res)
    );

    credit_out i_credit_out (
        .clk (clk), .rst (rst), .res_valid (res_valid), .res (res),
        .credit_ret (credit_ret), .out_valid (out_valid), .out_data (out_data),
        .drop_count (drop_count)
    );

endmodule

//--- verif/tb_audio_mix.sv
// tb_audio_mix: directed testbench for the two-channel audio mixer with a credit-returning sink
`timescale 1ns/10ps

module tb_audio_mix
    import mix_pkg::*;
;

    // tests run a few hundred cycles, this leaves a wide margin
    localparam int TIMEOUT_CYC = 4000;
    localparam int CLK_HALF = 2;
    localparam int RAND_LIM = 8000;
    // strobes beyond the granted credits in the exhaustion test
    localparam int EXTRA_FRAMES = 3;
    localparam int RESUME_FRAMES = 6;

    logic              clk;
    logic              rst;
    logic              sample;
    mix_frame_t        in_frame;
    mix_cfg_t          cfg;
    logic              credit_ret = 1'b0;
    logic              out_valid;
    mix_out_t          out_data;
    logic [DROP_W-1:0] drop_count;

    integer     seed = 32'he14d_fe86;
    int         cyc = 0;
    int         mismatch_count = 0;
    int         fail_count = 0;
    // model filter state, one pair of poles per channel
    int         pole1_y[NUM_CH];
    int         pole2_y[NUM_CH];
    // model results in strobe order
    mix_out_t   exp_q[$];
    // strobe seen on the last four falling edges
    logic [3:0] strobe_hist = '0;
    int         model_credits = CREDITS_MAX;
    logic       exp_valid = 1'b0;
    mix_out_t   exp_beat;
    logic       send_now;
    int         beat_count = 0;
    int         returned = 0;
    logic       sink_en;

    audio_mix_top i_audio_mix_top (
        .clk        (clk),
        .rst        (rst),
        .sample     (sample),
        .in_frame   (in_frame),
        .cfg        (cfg),
        .credit_ret (credit_ret),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .drop_count (drop_count)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk) begin
        if (cyc >= TIMEOUT_CYC) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("=== FAIL ===");
            $finish;
        end else begin
            cyc <= cyc + 1;
        end
    end

    // sink hands back one credit per cycle for every beat it holds
    always @(posedge clk) begin
        if (sink_en && (beat_count > returned)) begin
            credit_ret <= 1'b1;
            returned   <= returned + 1;
        end else begin
            credit_ret <= 1'b0;
        end
    end

    function automatic int pole_step(input int y_prev, input int x, input int a);
        // a of zero passes x through, otherwise both products floor
        if (a == 0) return x;
        return ((a * y_prev) >>> COEF_W) + ((((1 << COEF_W) - a) * x) >>> COEF_W);
    endfunction

    function automatic int saturate(input int v, inout bit clipped);
        int hi;
        int lo;
        hi = (1 << (SAMPLE_W - 1)) - 1;
        lo = -(1 << (SAMPLE_W - 1));
        if (v > hi) begin
            clipped = 1'b1;
            return hi;
        end else if (v < lo) begin
            clipped = 1'b1;
            return lo;
        end
        return v;
    endfunction

    // one strobe through poles, gain and sum, advancing the model state
    function automatic mix_out_t model_frame(input mix_frame_t f);
        int        x[NUM_CH];
        int        g[NUM_CH];
        int        s;
        bit        clipped;
        chan_cfg_t cc;
        mix_out_t  r;
        x[0] = f.ch0;
        x[1] = f.ch1;
        clipped = 1'b0;
        for (int c = 0; c < NUM_CH; c++) begin
            cc = (c == 0) ? cfg.ch0 : cfg.ch1;
            pole1_y[c] = pole_step(pole1_y[c], x[c], int'(cc.a1));
            pole2_y[c] = pole_step(pole2_y[c], pole1_y[c], int'(cc.a2));
            g[c] = saturate((pole2_y[c] * int'(cc.gain)) >>> GAIN_FRAC, clipped);
        end
        s = saturate(g[0] + g[1], clipped);
        r.data = SAMPLE_W'(s);
        r.clip = clipped;
        return r;
    endfunction

    function automatic mix_frame_t make_frame(input int c0, input int c1);
        mix_frame_t f;
        f.ch0 = SAMPLE_W'(c0);
        f.ch1 = SAMPLE_W'(c1);
        return f;
    endfunction

    function automatic int rand_sample();
        return $random(seed) % (RAND_LIM + 1);
    endfunction

    task automatic check_out(input mix_out_t act, input mix_out_t exp, input string what);
        if (act !== exp) begin
            mismatch_count++;
            $display("MISMATCH %0t: %s data %0d clip %0b, expected data %0d clip %0b",
                     $time, what, act.data, act.clip, exp.data, exp.clip);
        end
    endtask

    task automatic check_drops(input logic [DROP_W-1:0] act, input logic [DROP_W-1:0] exp);
        if (act !== exp) begin
            mismatch_count++;
            $display("MISMATCH %0t: drop_count %0d, expected %0d", $time, act, exp);
        end
    endtask

    task automatic compare_count(input int act, input int exp, input string what);
        if (act != exp) begin
            mismatch_count++;
            $display("MISMATCH %0t: %s %0d, expected %0d", $time, what, act, exp);
        end
    endtask

    // same settings on both channels, taken up on the next edge
    task automatic set_cfg(input logic [COEF_W-1:0] a1, input logic [COEF_W-1:0] a2,
                           input logic [GAIN_W-1:0] gain);
        chan_cfg_t cc;
        cc.a1   = a1;
        cc.a2   = a2;
        cc.gain = gain;
        @(posedge clk);
        cfg <= {cc, cc};
    endtask

    // one strobe, then quiet cycles so strobes are 4 cycles apart
    task automatic send_frame(input mix_frame_t f);
        @(posedge clk);
        sample   <= 1'b1;
        in_frame <= f;
        exp_q.push_back(model_frame(f));
        @(posedge clk);
        sample <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    // the last strobe has left the history and its beat has been checked
    task automatic wait_idle();
        do begin
            @(posedge clk);
        end while ((strobe_hist != '0) || exp_valid);
    endtask

    task automatic bypass_mix();
        set_cfg(8'd0, 8'd0, 8'd16);
        send_frame(make_frame(1000, 2000));
        send_frame(make_frame(-5000, 300));
        // sums beyond the sample range clamp
        send_frame(make_frame(20000, 20000));
        send_frame(make_frame(-20000, -20000));
        send_frame(make_frame(32767, -32768));
        send_frame(make_frame(0, 0));
        wait_idle();
        @(negedge clk);
        check_drops(drop_count, '0);
    endtask

    task automatic step_and_random();
        int c0;
        int c1;
        set_cfg(8'd200, 8'd128, 8'd16);
        // step response rises towards the input level
        for (int i = 0; i < 16; i++) begin
            send_frame(make_frame(10000, -6000));
        end
        for (int i = 0; i < 32; i++) begin
            c0 = rand_sample();
            c1 = rand_sample();
            send_frame(make_frame(c0, c1));
        end
        wait_idle();
        @(negedge clk);
        check_drops(drop_count, '0);
    endtask

    task automatic gain_clamp();
        set_cfg(8'd0, 8'd0, 8'd48);
        // gain 3.0 pushes these past full scale
        send_frame(make_frame(20000, 100));
        send_frame(make_frame(-20000, -100));
        send_frame(make_frame(12000, 12000));
        // small levels stay clear of the clip flag
        send_frame(make_frame(1000, -2000));
        send_frame(make_frame(300, 400));
        wait_idle();
        @(negedge clk);
        check_drops(drop_count, '0);
    endtask

    task automatic exhaust_credits();
        int beats_before;
        set_cfg(8'd64, 8'd128, 8'd16);
        while (model_credits != CREDITS_MAX) @(posedge clk);
        sink_en <= 1'b0;
        beats_before = beat_count;
        for (int i = 0; i < CREDITS_MAX + EXTRA_FRAMES; i++) begin
            send_frame(make_frame(i * 500, -i * 300));
        end
        wait_idle();
        @(negedge clk);
        compare_count(beat_count - beats_before, CREDITS_MAX, "beats without returned credits");
        check_drops(drop_count, DROP_W'(EXTRA_FRAMES));
    endtask

    task automatic resume_credits();
        int beats_before;
        int c0;
        int c1;
        sink_en <= 1'b1;
        while (model_credits != CREDITS_MAX) @(posedge clk);
        beats_before = beat_count;
        for (int i = 0; i < RESUME_FRAMES; i++) begin
            c0 = rand_sample();
            c1 = rand_sample();
            send_frame(make_frame(c0, c1));
        end
        wait_idle();
        @(negedge clk);
        compare_count(beat_count - beats_before, RESUME_FRAMES, "beats after credit return");
        check_drops(drop_count, DROP_W'(EXTRA_FRAMES));
    endtask

    // falling edge, outputs are settled here
    always @(negedge clk) begin
        if (!rst) begin
            if (out_valid && !exp_valid) begin
                fail_count++;
                $display("%0t: a beat came out although no result was due", $time);
            end else if (!out_valid && exp_valid) begin
                fail_count++;
                $display("%0t: an expected beat did not come out", $time);
            end else if (out_valid) begin
                check_out(out_data, exp_beat, "beat");
            end
            if (out_valid) beat_count++;
            // result of the strobe four edges back meets the credit check next edge
            send_now = strobe_hist[3] && (model_credits > 0);
            if (strobe_hist[3]) begin
                if (exp_q.size() == 0) begin
                    fail_count++;
                    $display("%0t: a result was due but the model had none", $time);
                end else begin
                    exp_beat = exp_q.pop_front();
                end
            end
            // credit_ret seen now is counted on the same edge as the send
            model_credits = model_credits - int'(send_now) + int'(credit_ret);
            exp_valid = send_now;
        end
        strobe_hist = {strobe_hist[2:0], sample};
    end

    initial begin
        rst      = 1'b1;
        sample   = 1'b0;
        in_frame = '0;
        cfg      = '0;
        sink_en  = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        bypass_mix();
        step_and_random();
        gain_clamp();
        exhaust_credits();
        resume_credits();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if ((mismatch_count == 0) && (fail_count == 0)) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- all.f
common/mix_pkg.sv
design/pole/pole_filter.sv
design/pole/pole_cascade.sv
design/chan_gain.sv
design/mix_sum.sv
design/credit_out.sv
design/audio_mix_top.sv
verif/tb_audio_mix.sv

//--- Makefile
# Verilator build and run for the audio mixer testbench

VERILATOR ?= verilator
TOP       ?= tb_audio_mix
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j $(JOBS)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, pass only if the pass line is printed"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(BUILD_DIR)
